//--- apbMaster.sv
`timescale 1ns/1ps

module apbMaster (
  input  logic         clk,
  input  logic         reset,
  memReqIf.master      mem,
  output logic         psel,
  output logic         penable,
  output logic         pwrite,
  output cpuPkg::wordT paddr,
  output cpuPkg::wordT pwdata,
  input  cpuPkg::wordT prdata,
  input  logic         pready
);

  logic         doneQ;
  cpuPkg::wordT rdataQ;
  logic         accessDone;

  assign accessDone = psel && penable && pready;
  assign mem.done   = doneQ;
  assign mem.rdata  = rdataQ;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      doneQ   <= 1'b0;
    end else begin
      doneQ <= accessDone;
      if (mem.start) begin
        psel    <= 1'b1;  // Setup phase
        penable <= 1'b0;
        pwrite  <= mem.write;
      end else if (psel && !penable) begin
        penable <= 1'b1;  // Access phase
      end else if (accessDone) begin
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem.start) begin
      paddr  <= mem.addr;
      pwdata <= mem.wdata;
    end
    if (accessDone) rdataQ <= prdata;
  end

endmodule

//--- cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
  input  logic         clk,
  input  logic         reset,
  output logic         psel,
  output logic         penable,
  output logic         pwrite,
  output cpuPkg::wordT paddr,
  output cpuPkg::wordT pwdata,
  input  cpuPkg::wordT prdata,
  input  logic         pready,
  output cpuPkg::wordT debugValue,
  output logic         debugValid
);

  cpuPkg::opcodeT opcode;
  cpuPkg::wordT   constWord;
  cpuPkg::wordT   memData;
  cpuPkg::wordT   ip;
  cpuPkg::wordT   memAddr;
  cpuPkg::wordT   storeData;
  cpuPkg::wordT   jumpTarget;
  cpuPkg::wordT   aluResult;
  logic           ipStep;
  logic           ipLoad;
  logic           wide;
  logic           takeBranch;

  memReqIf  memBus ();
  regBankIf rbIf ();

  assign rbIf.wrData = aluResult;  // Destination write data

  instrSequencer uSeq (
    .clk        (clk),
    .reset      (reset),
    .mem        (memBus),
    .regs       (rbIf),
    .opcode     (opcode),
    .constWord  (constWord),
    .memData    (memData),
    .ipStep     (ipStep),
    .ipLoad     (ipLoad),
    .wide       (wide),
    .debugValid (debugValid),
    .ip         (ip),
    .memAddr    (memAddr),
    .storeData  (storeData),
    .takeBranch (takeBranch)
  );

  instrPointer uIp (
    .clk    (clk),
    .reset  (reset),
    .step   (ipStep),
    .load   (ipLoad),
    .wide   (wide),
    .target (jumpTarget),
    .ip     (ip)
  );

  registerBank uRegs (
    .clk   (clk),
    .reset (reset),
    .regs  (rbIf)
  );

  execUnit uExec (
    .opcode     (opcode),
    .constWord  (constWord),
    .memData    (memData),
    .ip         (ip),
    .regs       (rbIf),
    .result     (aluResult),
    .memAddr    (memAddr),
    .storeData  (storeData),
    .jumpTarget (jumpTarget),
    .takeBranch (takeBranch),
    .debugValue (debugValue)
  );

  apbMaster uApb (
    .clk     (clk),
    .reset   (reset),
    .mem     (memBus),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready)
  );

endmodule

//--- cpuPkg.sv
package cpuPkg;

  typedef logic [31:0]       wordT;    // Data and address word
  typedef logic [2:0]        regIdxT;  // Low bits of each register byte
  typedef logic signed [3:0] stepT;    // Stack pointer step

  localparam int NumRegs   = 8;
  localparam int StackReg  = 0;  // Stack pointer lives here
  localparam int FlagReg   = 1;  // Compare flags live here
  localparam int WordBytes = 4;

  // Instruction word field positions
  localparam int OpcodeLsb = 0;
  localparam int Reg1Lsb   = 8;
  localparam int Reg2Lsb   = 16;
  localparam int Reg3Lsb   = 24;

  // Flag register bits
  localparam int FlagEq = 0;
  localparam int FlagLt = 1;
  localparam int FlagGt = 2;

  typedef enum logic [7:0] {
    movRC   = 8'h01, movRR   = 8'h02, movRdC  = 8'h03, movRdRo = 8'h04,
    movdCR  = 8'h05, movdRoR = 8'h06, pushR   = 8'h07, popR    = 8'h08,
    callR   = 8'h09, ret     = 8'h0a, cmpRR   = 8'h0b, cmpRC   = 8'h0c,
    jmpC    = 8'h0d, jeC     = 8'h0e, jneC    = 8'h0f, jzRC    = 8'h10,
    jnzRC   = 8'h11, addRRC  = 8'h12, addRRR  = 8'h13, subRRC  = 8'h14,
    subRRR  = 8'h15, incR    = 8'h16, decR    = 8'h17, negRR   = 8'h18,
    doutR   = 8'h19, stall   = 8'h1a
  } opcodeT;

  typedef enum logic [3:0] {
    idle, fetchReq, fetchWait, decode, operandRead,
    wordReq, wordWait, memReq, memWait, execute
  } seqStateT;

  // Opcodes followed by a constant word
  function automatic logic Is8Byte(opcodeT op);
    case (op)
      movRC, movRdC, movRdRo, movdCR, movdRoR, cmpRC,
      jmpC, jeC, jneC, jzRC, jnzRC, addRRC, subRRC: return 1'b1;
      default:                                      return 1'b0;
    endcase
  endfunction

  // Opcodes that need a data transfer after fetch
  function automatic logic IsMemOp(opcodeT op);
    case (op)
      movRdC, movRdRo, movdCR, movdRoR, pushR, popR, callR, ret: return 1'b1;
      default:                                                   return 1'b0;
    endcase
  endfunction

endpackage

//--- execUnit.sv
`timescale 1ns/1ps

module execUnit (
  input  cpuPkg::opcodeT opcode,
  input  cpuPkg::wordT   constWord,
  input  cpuPkg::wordT   memData,
  input  cpuPkg::wordT   ip,
  regBankIf.data         regs,
  output cpuPkg::wordT   result,
  output cpuPkg::wordT   memAddr,
  output cpuPkg::wordT   storeData,
  output cpuPkg::wordT   jumpTarget,
  output logic           takeBranch,
  output cpuPkg::wordT   debugValue
);

  cpuPkg::wordT cmpRhs;
  logic         isPopLike;

  assign isPopLike = (opcode == cpuPkg::popR) || (opcode == cpuPkg::ret);
  assign cmpRhs    = (opcode == cpuPkg::cmpRC) ? constWord : regs.rdData2;

  // Unsigned compare of first operand
  always_comb begin
    regs.flagData = '0;
    regs.flagData[cpuPkg::FlagEq] = (regs.rdData1 == cmpRhs);
    regs.flagData[cpuPkg::FlagLt] = (regs.rdData1 < cmpRhs);
    regs.flagData[cpuPkg::FlagGt] = (regs.rdData1 > cmpRhs);
  end

  // Stack grows upward
  assign regs.spStep = isPopLike ? -cpuPkg::stepT'(cpuPkg::WordBytes)
                                 : cpuPkg::stepT'(cpuPkg::WordBytes);

  always_comb begin
    case (opcode)
      cpuPkg::movRC:                               result = constWord;
      cpuPkg::movRR:                               result = regs.rdData2;
      cpuPkg::movRdC, cpuPkg::movRdRo, cpuPkg::popR: result = memData;  // Loaded word
      cpuPkg::addRRC:                              result = regs.rdData2 + constWord;
      cpuPkg::addRRR:                              result = regs.rdData2 + regs.rdData3;
      cpuPkg::subRRC:                              result = regs.rdData2 - constWord;
      cpuPkg::subRRR:                              result = regs.rdData2 - regs.rdData3;
      cpuPkg::incR:                                result = regs.rdData1 + cpuPkg::wordT'(1);
      cpuPkg::decR:                                result = regs.rdData1 - cpuPkg::wordT'(1);
      cpuPkg::negRR:                               result = -regs.rdData2;
      default:                                     result = '0;
    endcase
  end

  // Data address
  always_comb begin
    case (opcode)
      cpuPkg::movRdRo:              memAddr = regs.rdData2 + constWord;  // Base in field 2
      cpuPkg::movdRoR:              memAddr = regs.rdData1 + constWord;  // Base in field 1
      cpuPkg::pushR, cpuPkg::callR: memAddr = regs.sp;
      cpuPkg::popR, cpuPkg::ret:    memAddr = regs.sp - cpuPkg::wordT'(cpuPkg::WordBytes);
      default:                      memAddr = constWord;  // Absolute forms
    endcase
  end

  always_comb begin
    case (opcode)
      cpuPkg::pushR: storeData = regs.rdData1;
      cpuPkg::callR: storeData = ip;  // Return address is the call itself
      default:       storeData = regs.rdData2;
    endcase
  end

  // Conditional branches only
  always_comb begin
    case (opcode)
      cpuPkg::jeC:   takeBranch = regs.flags[cpuPkg::FlagEq];
      cpuPkg::jneC:  takeBranch = !regs.flags[cpuPkg::FlagEq];
      cpuPkg::jzRC:  takeBranch = (regs.rdData3 == '0);
      cpuPkg::jnzRC: takeBranch = (regs.rdData3 != '0);
      default:       takeBranch = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      cpuPkg::callR: jumpTarget = regs.rdData1;
      cpuPkg::ret:   jumpTarget = memData + cpuPkg::wordT'(cpuPkg::WordBytes);  // Skip the call
      default:       jumpTarget = constWord;
    endcase
  end

  assign debugValue = regs.rdData1;  // doutR source

endmodule

//--- filelist.f
+incdir+.
cpuPkg.sv
memReqIf.sv
instrSequencer.sv
instrPointer.sv
registerBank.sv
execUnit.sv
apbMaster.sv
cpuCore.sv
tbCpu.sv

//--- instrPointer.sv
`timescale 1ns/1ps

module instrPointer (
  input  logic         clk,
  input  logic         reset,
  input  logic         step,    // Advance past current instruction
  input  logic         load,    // Jump, call, ret or taken branch
  input  logic         wide,    // Current instruction has a constant word
  input  cpuPkg::wordT target,
  output cpuPkg::wordT ip
);

  cpuPkg::wordT stride;

  // One or two words
  assign stride = wide ? cpuPkg::wordT'(2 * cpuPkg::WordBytes)
                       : cpuPkg::wordT'(cpuPkg::WordBytes);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ip <= '0;
    end else if (load) begin
      ip <= target;  // Load wins over step
    end else if (step) begin
      ip <= ip + stride;
    end
  end

endmodule

//--- instrSequencer.sv
`timescale 1ns/1ps

module instrSequencer (
  input  logic                clk,
  input  logic                reset,
  memReqIf.sequencer          mem,
  regBankIf.ctrl              regs,
  output cpuPkg::opcodeT      opcode,
  output cpuPkg::wordT        constWord,
  output cpuPkg::wordT        memData,
  output logic                ipStep,
  output logic                ipLoad,
  output logic                wide,        // Latched Is8Byte
  output logic                debugValid,
  input  cpuPkg::wordT        ip,
  input  cpuPkg::wordT        memAddr,
  input  cpuPkg::wordT        storeData,
  input  logic                takeBranch
);

  cpuPkg::seqStateT state;
  cpuPkg::regIdxT   field1, field2, field3;
  logic             isMem;      // Latched IsMemOp
  logic             halted;     // Set by stall and cleared only by reset
  logic             inExec;
  logic             isStore;
  logic             isJump;

  assign inExec  = (state == cpuPkg::execute);
  assign isStore = opcode inside {cpuPkg::movdCR, cpuPkg::movdRoR, cpuPkg::pushR, cpuPkg::callR};
  assign isJump  = opcode inside {cpuPkg::jmpC, cpuPkg::callR, cpuPkg::ret};

  // Each request state lasts one cycle
  assign mem.start = (state == cpuPkg::fetchReq) || (state == cpuPkg::wordReq) ||
                     (state == cpuPkg::memReq);
  assign mem.write = (state == cpuPkg::memReq) && isStore;
  assign mem.wdata = storeData;

  always_comb begin
    case (state)
      cpuPkg::wordReq: mem.addr = ip + cpuPkg::wordT'(cpuPkg::WordBytes);  // Constant word
      cpuPkg::memReq:  mem.addr = memAddr;
      default:         mem.addr = ip;
    endcase
  end

  // Register file control
  assign regs.rdIdx1 = field1;
  assign regs.rdIdx2 = field2;
  assign regs.rdIdx3 = field3;
  assign regs.wrIdx  = field1;  // Destination is always the first field
  assign regs.wrEn   = inExec && (opcode inside {
                         cpuPkg::movRC, cpuPkg::movRR, cpuPkg::movRdC, cpuPkg::movRdRo,
                         cpuPkg::popR, cpuPkg::addRRC, cpuPkg::addRRR, cpuPkg::subRRC,
                         cpuPkg::subRRR, cpuPkg::incR, cpuPkg::decR, cpuPkg::negRR});
  assign regs.spEn   = inExec && (opcode inside {
                         cpuPkg::pushR, cpuPkg::popR, cpuPkg::callR, cpuPkg::ret});
  assign regs.flagEn = inExec && (opcode inside {cpuPkg::cmpRR, cpuPkg::cmpRC});

  // Pointer moves at the end of execute
  assign ipLoad = inExec && (isJump || takeBranch);
  assign ipStep = inExec && !ipLoad && (opcode != cpuPkg::stall);  // Stall holds

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= cpuPkg::idle;
      wide       <= 1'b0;
      isMem      <= 1'b0;
      halted     <= 1'b0;
      debugValid <= 1'b0;
    end else begin
      debugValid <= inExec && (opcode == cpuPkg::doutR);
      case (state)
        cpuPkg::idle:      if (!halted) state <= cpuPkg::fetchReq;
        cpuPkg::fetchReq:  state <= cpuPkg::fetchWait;
        cpuPkg::fetchWait: if (mem.done) state <= cpuPkg::decode;
        cpuPkg::decode: begin
          wide  <= cpuPkg::Is8Byte(opcode);
          isMem <= cpuPkg::IsMemOp(opcode);  // Unknown opcodes give neither
          state <= cpuPkg::operandRead;
        end
        cpuPkg::operandRead: begin
          if (wide)       state <= cpuPkg::wordReq;
          else if (isMem) state <= cpuPkg::memReq;
          else            state <= cpuPkg::execute;
        end
        cpuPkg::wordReq:  state <= cpuPkg::wordWait;
        cpuPkg::wordWait: if (mem.done) state <= isMem ? cpuPkg::memReq : cpuPkg::execute;
        cpuPkg::memReq:   state <= cpuPkg::memWait;
        cpuPkg::memWait:  if (mem.done) state <= cpuPkg::execute;
        cpuPkg::execute: begin
          if (opcode == cpuPkg::stall) begin
            halted <= 1'b1;  // Park until reset
            state  <= cpuPkg::idle;
          end else begin
            state <= cpuPkg::fetchReq;
          end
        end
        default: state <= cpuPkg::idle;
      endcase
    end
  end

  // Instruction and data capture
  always_ff @(posedge clk) begin
    if (state == cpuPkg::fetchWait && mem.done) begin
      opcode <= cpuPkg::opcodeT'(mem.rdata[cpuPkg::OpcodeLsb +: 8]);
      field1 <= mem.rdata[cpuPkg::Reg1Lsb +: $bits(cpuPkg::regIdxT)];
      field2 <= mem.rdata[cpuPkg::Reg2Lsb +: $bits(cpuPkg::regIdxT)];
      field3 <= mem.rdata[cpuPkg::Reg3Lsb +: $bits(cpuPkg::regIdxT)];
    end
    if (state == cpuPkg::wordWait && mem.done) constWord <= mem.rdata;
    if (state == cpuPkg::memWait && mem.done)  memData   <= mem.rdata;  // Load, pop or ret
  end

endmodule

//--- memReqIf.sv
`timescale 1ns/1ps

// One memory transfer from the sequencer to the APB master
interface memReqIf;
  logic         start;  // One-cycle request pulse
  logic         write;
  cpuPkg::wordT addr;
  cpuPkg::wordT wdata;
  cpuPkg::wordT rdata;  // Valid with done
  logic         done;   // One-cycle completion pulse

  modport sequencer (output start, write, addr, wdata, input rdata, done);
  modport master (input start, write, addr, wdata, output rdata, done);
endinterface

// Register file access shared by control, datapath and storage
interface regBankIf;
  cpuPkg::regIdxT rdIdx1, rdIdx2, rdIdx3;
  cpuPkg::wordT   rdData1, rdData2, rdData3;
  cpuPkg::wordT   sp;        // Full register 0
  cpuPkg::wordT   flags;     // Full register 1
  logic           wrEn;
  cpuPkg::regIdxT wrIdx;
  cpuPkg::wordT   wrData;
  logic           spEn;
  cpuPkg::stepT   spStep;
  logic           flagEn;
  cpuPkg::wordT   flagData;

  modport ctrl (output rdIdx1, rdIdx2, rdIdx3, wrEn, wrIdx, spEn, flagEn);
  modport data (input rdData1, rdData2, rdData3, sp, flags, output spStep, flagData);
  modport bank (
    input  rdIdx1, rdIdx2, rdIdx3, wrEn, wrIdx, wrData, spEn, spStep, flagEn, flagData,
    output rdData1, rdData2, rdData3, sp, flags
  );
endinterface

//--- registerBank.sv
`timescale 1ns/1ps

module registerBank (
  input  logic   clk,
  input  logic   reset,
  regBankIf.bank regs
);

  cpuPkg::wordT regFile [cpuPkg::NumRegs];
  cpuPkg::wordT spDelta;

  // Sign-extended stack step
  assign spDelta = cpuPkg::wordT'(regs.spStep);

  // Combinational reads
  assign regs.rdData1 = regFile[regs.rdIdx1];
  assign regs.rdData2 = regFile[regs.rdIdx2];
  assign regs.rdData3 = regFile[regs.rdIdx3];
  assign regs.sp      = regFile[cpuPkg::StackReg];
  assign regs.flags   = regFile[cpuPkg::FlagReg];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < cpuPkg::NumRegs; i++) begin
        regFile[i] <= '0;
      end
    end else begin
      if (regs.wrEn) regFile[regs.wrIdx] <= regs.wrData;
      // Later writes win so a pop into r0 keeps the stack update
      if (regs.spEn) regFile[cpuPkg::StackReg] <= regFile[cpuPkg::StackReg] + spDelta;
      if (regs.flagEn) regFile[cpuPkg::FlagReg] <= regs.flagData;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tbCpu -o simCpu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/simCpu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulator exited with an error"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

//--- tbRefModel.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [31:0] progImg [256];  // Memory image shared by DUT memory and reference
int          pc;             // Builder write position in bytes
logic [31:0] stallAddr;      // Where the reference reached stall
logic [31:0] expDbg [$];
logic [31:0] expWrAddr [$];
logic [31:0] expWrData [$];

function automatic void emitOp(cpuPkg::opcodeT op, int f1, int f2, int f3);
  progImg[pc / 4] = {5'b0, 3'(f3), 5'b0, 3'(f2), 5'b0, 3'(f1), 8'(op)};
  pc += 4;
endfunction

function automatic void emitOpConst(cpuPkg::opcodeT op, int f1, int f2, int f3,
                                    logic [31:0] c);
  emitOp(op, f1, f2, f3);
  progImg[pc / 4] = c;  // Constant follows the opcode word
  pc += 4;
endfunction

// Branch over one doutR so that a taken branch drops its value
function automatic void condSkip(cpuPkg::opcodeT op, int f3, int dbgReg);
  logic [31:0] target;
  target = 32'(pc + 12);
  emitOpConst(op, 0, 0, f3, target);
  emitOp(cpuPkg::doutR, dbgReg, 0, 0);
endfunction

function automatic void buildProgram();
  int          patchCall;
  int          patchJump;
  int          depth;
  int          kind;
  int          rd;
  int          ra;
  int          rb;
  logic [31:0] k;
  logic [31:0] addr;
  for (int i = 0; i < 256; i++) begin
    progImg[i] = 32'h5a5a0000 ^ (32'(i) * 32'h9e3779b9);  // Whole-address fill
  end
  pc = 0;
  emitOpConst(cpuPkg::movRC, 0, 0, 0, 32'h3c0);  // Stack base
  // Moves and arithmetic
  emitOpConst(cpuPkg::movRC, 2, 0, 0, 32'h12345678);
  emitOp(cpuPkg::doutR, 2, 0, 0);
  emitOp(cpuPkg::movRR, 3, 2, 0);
  emitOp(cpuPkg::doutR, 3, 0, 0);
  emitOpConst(cpuPkg::addRRC, 4, 3, 0, 32'hfffffff0);
  emitOp(cpuPkg::doutR, 4, 0, 0);
  emitOp(cpuPkg::addRRR, 5, 4, 2);
  emitOp(cpuPkg::doutR, 5, 0, 0);
  emitOpConst(cpuPkg::subRRC, 6, 2, 0, 32'h12345679);  // Wraps to all ones
  emitOp(cpuPkg::doutR, 6, 0, 0);
  emitOp(cpuPkg::subRRR, 7, 6, 5);
  emitOp(cpuPkg::doutR, 7, 0, 0);
  emitOp(cpuPkg::incR, 6, 0, 0);
  emitOp(cpuPkg::doutR, 6, 0, 0);
  emitOp(cpuPkg::decR, 6, 0, 0);
  emitOp(cpuPkg::doutR, 6, 0, 0);
  emitOp(cpuPkg::negRR, 4, 2, 0);
  emitOp(cpuPkg::doutR, 4, 0, 0);
  // Stores then loads back
  emitOpConst(cpuPkg::movdCR, 0, 2, 0, 32'h380);
  emitOpConst(cpuPkg::movRC, 3, 0, 0, 32'h390);
  emitOpConst(cpuPkg::movdRoR, 3, 5, 0, 32'h8);
  emitOpConst(cpuPkg::movRdC, 6, 0, 0, 32'h380);
  emitOp(cpuPkg::doutR, 6, 0, 0);
  emitOpConst(cpuPkg::movRdRo, 7, 3, 0, 32'h8);
  emitOp(cpuPkg::doutR, 7, 0, 0);
  // Stack
  emitOp(cpuPkg::pushR, 2, 0, 0);
  emitOp(cpuPkg::pushR, 5, 0, 0);
  emitOp(cpuPkg::popR, 6, 0, 0);
  emitOp(cpuPkg::popR, 7, 0, 0);
  emitOp(cpuPkg::doutR, 6, 0, 0);
  emitOp(cpuPkg::doutR, 7, 0, 0);
  emitOp(cpuPkg::doutR, 0, 0, 0);
  // Call over a subroutine placed after a jump
  emitOpConst(cpuPkg::movRC, 3, 0, 0, 32'h0);
  patchCall = pc - 4;
  emitOp(cpuPkg::callR, 3, 0, 0);
  emitOp(cpuPkg::doutR, 4, 0, 0);
  emitOp(cpuPkg::doutR, 0, 0, 0);
  emitOpConst(cpuPkg::jmpC, 0, 0, 0, 32'h0);
  patchJump = pc - 4;
  progImg[patchCall / 4] = 32'(pc);
  emitOp(cpuPkg::incR, 4, 0, 0);
  emitOp(cpuPkg::doutR, 4, 0, 0);
  emitOp(cpuPkg::ret, 0, 0, 0);
  progImg[patchJump / 4] = 32'(pc);
  // Compares and branches
  emitOp(cpuPkg::cmpRR, 2, 2, 0);
  condSkip(cpuPkg::jeC, 0, 5);
  condSkip(cpuPkg::jneC, 0, 5);
  emitOpConst(cpuPkg::cmpRC, 2, 0, 0, 32'h1);
  emitOp(cpuPkg::doutR, 1, 0, 0);
  condSkip(cpuPkg::jeC, 0, 5);
  condSkip(cpuPkg::jneC, 0, 5);
  emitOpConst(cpuPkg::movRC, 6, 0, 0, 32'h0);
  condSkip(cpuPkg::jzRC, 6, 5);
  condSkip(cpuPkg::jnzRC, 6, 5);
  condSkip(cpuPkg::jzRC, 2, 5);
  condSkip(cpuPkg::jnzRC, 2, 5);
  // Random part keeps destinations off the stack and flag registers
  depth = 0;
  for (int i = 0; i < 40; i++) begin
    if (pc > 32'h360) break;  // Keep clear of data and stack
    kind = int'(nextRandom() % 16);
    rd   = 2 + int'(nextRandom() % 6);
    ra   = int'(nextRandom() % 8);
    rb   = int'(nextRandom() % 8);
    k    = nextRandom();
    addr = 32'h380 + ((k % 16) * 4);
    case (kind)
      0:  emitOpConst(cpuPkg::movRC, rd, 0, 0, k);
      1:  emitOp(cpuPkg::movRR, rd, ra, 0);
      2:  emitOpConst(cpuPkg::addRRC, rd, ra, 0, k);
      3:  emitOp(cpuPkg::addRRR, rd, ra, rb);
      4:  emitOpConst(cpuPkg::subRRC, rd, ra, 0, k);
      5:  emitOp(cpuPkg::subRRR, rd, ra, rb);
      6:  emitOp(cpuPkg::incR, rd, 0, 0);
      7:  emitOp(cpuPkg::decR, rd, 0, 0);
      8:  emitOp(cpuPkg::negRR, rd, ra, 0);
      9:  emitOp(cpuPkg::cmpRR, ra, rb, 0);
      10: emitOpConst(cpuPkg::cmpRC, ra, 0, 0, k);
      11: emitOpConst(cpuPkg::movdCR, 0, ra, 0, addr);
      12: emitOpConst(cpuPkg::movRdC, rd, 0, 0, addr);
      13: begin
        if (depth < 8) begin
          emitOp(cpuPkg::pushR, ra, 0, 0);
          depth++;
        end else begin
          emitOp(cpuPkg::doutR, ra, 0, 0);
        end
      end
      14: begin
        if (depth > 0) begin
          emitOp(cpuPkg::popR, rd, 0, 0);
          depth--;
        end else begin
          emitOp(cpuPkg::doutR, ra, 0, 0);
        end
      end
      default: begin
        if (k[0]) condSkip(cpuPkg::jeC, 0, rd);
        else      condSkip(cpuPkg::jzRC, ra, rd);
      end
    endcase
    if (k[1]) emitOp(cpuPkg::doutR, rd, 0, 0);
  end
  emitOp(cpuPkg::stall, 0, 0, 0);
endfunction

function automatic logic [31:0] compareFlags(logic [31:0] a, logic [31:0] b);
  return {29'b0, a > b, a < b, a == b};  // Greater, less, equal
endfunction

// Instruction-level model that returns the count up to stall or -1 on runaway
function automatic int runReference();
  logic [31:0]    m [256];
  logic [31:0]    r [8];
  logic [31:0]    ip;
  logic [31:0]    w;
  logic [31:0]    c;
  logic [31:0]    a;
  logic [31:0]    next;
  logic [2:0]     f1;
  logic [2:0]     f2;
  logic [2:0]     f3;
  logic           wideOp;
  cpuPkg::opcodeT op;
  m  = progImg;
  ip = '0;
  for (int i = 0; i < 8; i++) r[i] = '0;
  for (int n = 1; n <= 5000; n++) begin
    w  = m[ip[9:2]];
    op = cpuPkg::opcodeT'(w[7:0]);
    f1 = w[10:8];
    f2 = w[18:16];
    f3 = w[26:24];
    a  = ip + 4;
    c  = m[a[9:2]];
    wideOp = op inside {cpuPkg::movRC, cpuPkg::movRdC, cpuPkg::movRdRo, cpuPkg::movdCR,
                        cpuPkg::movdRoR, cpuPkg::cmpRC, cpuPkg::jmpC, cpuPkg::jeC,
                        cpuPkg::jneC, cpuPkg::jzRC, cpuPkg::jnzRC, cpuPkg::addRRC,
                        cpuPkg::subRRC};
    next = ip + (wideOp ? 32'd8 : 32'd4);
    case (op)
      cpuPkg::movRC:   r[f1] = c;
      cpuPkg::movRR:   r[f1] = r[f2];
      cpuPkg::movRdC:  r[f1] = m[c[9:2]];
      cpuPkg::movRdRo: begin
        a     = r[f2] + c;
        r[f1] = m[a[9:2]];
      end
      cpuPkg::movdCR: begin
        m[c[9:2]] = r[f2];
        expWrAddr.push_back(c);
        expWrData.push_back(r[f2]);
      end
      cpuPkg::movdRoR: begin
        a         = r[f1] + c;
        m[a[9:2]] = r[f2];
        expWrAddr.push_back(a);
        expWrData.push_back(r[f2]);
      end
      cpuPkg::pushR: begin
        m[r[0][9:2]] = r[f1];
        expWrAddr.push_back(r[0]);
        expWrData.push_back(r[f1]);
        r[0] = r[0] + 4;
      end
      cpuPkg::popR: begin
        a     = r[0] - 4;
        r[f1] = m[a[9:2]];
        r[0]  = a;  // Pointer update wins for r0
      end
      cpuPkg::callR: begin
        m[r[0][9:2]] = ip;  // Return address saved as the call itself
        expWrAddr.push_back(r[0]);
        expWrData.push_back(ip);
        next = r[f1];
        r[0] = r[0] + 4;
      end
      cpuPkg::ret: begin
        a    = r[0] - 4;
        next = m[a[9:2]] + 4;
        r[0] = a;
      end
      cpuPkg::cmpRR:  r[1] = compareFlags(r[f1], r[f2]);
      cpuPkg::cmpRC:  r[1] = compareFlags(r[f1], c);
      cpuPkg::jmpC:   next = c;
      cpuPkg::jeC:    if (r[1][0]) next = c;
      cpuPkg::jneC:   if (!r[1][0]) next = c;
      cpuPkg::jzRC:   if (r[f3] == 0) next = c;
      cpuPkg::jnzRC:  if (r[f3] != 0) next = c;
      cpuPkg::addRRC: r[f1] = r[f2] + c;
      cpuPkg::addRRR: r[f1] = r[f2] + r[f3];
      cpuPkg::subRRC: r[f1] = r[f2] - c;
      cpuPkg::subRRR: r[f1] = r[f2] - r[f3];
      cpuPkg::incR:   r[f1] = r[f1] + 1;
      cpuPkg::decR:   r[f1] = r[f1] - 1;
      cpuPkg::negRR:  r[f1] = -r[f2];
      cpuPkg::doutR:  expDbg.push_back(r[f1]);
      cpuPkg::stall: begin
        stallAddr = ip;
        return n;
      end
      default:        next = ip + 4;  // Unknown is a one-word no-op
    endcase
    ip = next;
  end
  return -1;
endfunction

`endif

//--- tbCpu.sv
`timescale 1ns/1ps

module tbCpu;

  logic         clk;
  logic         reset;
  logic         psel;
  logic         penable;
  logic         pwrite;
  cpuPkg::wordT paddr;
  cpuPkg::wordT pwdata;
  cpuPkg::wordT prdata;
  logic         pready;
  cpuPkg::wordT debugValue;
  logic         debugValid;

  logic [31:0] mem [256];            // APB slave memory
  logic [31:0] rngState = 32'he7c8fbc5;
  logic [31:0] gotWrAddr [$];        // Completed APB writes awaiting comparison
  logic [31:0] gotWrData [$];
  int          waitLeft;
  int          refInstrs = 0;
  int          valueErrors = 0;
  int          otherErrors = 0;

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  `include "tbRefModel.svh"

  cpuCore u_dut (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .debugValue (debugValue),
    .debugValid (debugValid)
  );

  always #5 clk = ~clk;

  // APB slave with 0 to 3 wait states drawn on the falling edge
  always @(negedge clk) begin
    if (reset) begin
      pready   = 1'b0;
      waitLeft = 0;
    end else if (psel && !penable) begin
      waitLeft = int'(nextRandom() % 4);  // Setup phase
      pready   = 1'b0;
    end else if (psel && penable) begin
      if (waitLeft == 0) begin
        pready = 1'b1;  // Completes at next rising edge
        if (pwrite) begin
          mem[paddr[9:2]] = pwdata;
          gotWrAddr.push_back(paddr);
          gotWrData.push_back(pwdata);
        end
      end else begin
        waitLeft--;
        pready = 1'b0;
      end
    end else begin
      pready = 1'b0;
    end
    if (psel) prdata = mem[paddr[9:2]];
  end

  task automatic checkDebug(logic [31:0] got);
    logic [31:0] exp;
    assert (expDbg.size() > 0) else begin
      otherErrors++;
      $display("At %0t a debugValid pulse came with no value left to expect", $time);
    end
    if (expDbg.size() > 0) begin
      exp = expDbg.pop_front();
      assert (got == exp) else begin
        valueErrors++;
        $display("ERROR %0t debugValue got %h expected %h", $time, got, exp);
      end
    end
  endtask

  task automatic checkWrite(logic [31:0] addr, logic [31:0] data);
    logic [31:0] expAddr;
    logic [31:0] expData;
    assert (expWrAddr.size() > 0) else begin
      otherErrors++;
      $display("At %0t an APB write to %h came with no write left to expect", $time, addr);
    end
    if (expWrAddr.size() > 0) begin
      expAddr = expWrAddr.pop_front();
      expData = expWrData.pop_front();
      assert (addr == expAddr) else begin
        valueErrors++;
        $display("ERROR %0t paddr got %h expected %h", $time, addr, expAddr);
      end
      assert (data == expData) else begin
        valueErrors++;
        $display("ERROR %0t pwdata got %h expected %h", $time, data, expData);
      end
    end
  endtask

  // Comparison process
  always @(negedge clk) begin
    if (!reset) begin
      while (gotWrAddr.size() > 0) begin
        checkWrite(gotWrAddr.pop_front(), gotWrData.pop_front());
      end
      if (debugValid) checkDebug(debugValue);
    end
  end

  // Watchdog allows 200 cycles per reference instruction
  initial begin
    wait (refInstrs != 0);
    #((refInstrs > 0 ? refInstrs : 1) * 2000 + 2000);
    $display("Timeout: the DUT did not produce all expected results in time");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    clk    = 1'b0;
    reset  = 1'b1;
    pready = 1'b0;
    prdata = '0;
    buildProgram();
    mem       = progImg;
    refInstrs = runReference();
    assert (refInstrs > 0) else begin
      otherErrors++;
      $display("The reference model never reached the stall instruction");
    end
    repeat (2) @(negedge clk);
    reset = 1'b0;
    if (refInstrs > 0) begin
      while (expDbg.size() != 0 || expWrAddr.size() != 0 || gotWrAddr.size() != 0) begin
        @(negedge clk);
      end
      // Setup phase of the stall fetch
      while (!(psel && !penable && !pwrite && paddr == stallAddr)) begin
        @(negedge clk);
      end
      while (psel) begin
        @(negedge clk);
      end
      repeat (50) begin
        @(negedge clk);
        assert (!psel) else begin
          otherErrors++;
          $display("At %0t an APB transfer started after the stall", $time);
        end
      end
    end
    $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
